// File: Makefile
VERILATOR ?= verilator
TOP       ?= decode_unit_tb
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
SIM_ARGS  ?= +verilator+error+limit+100
PASS_TEXT ?= All tests passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

lint:
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR)

// File: dv/decode_unit_chk.sv
`timescale 1ns/100ps

module decode_unit_chk (
  input logic                      clk,
  input logic                      reset,
  input logic                      in_valid,
  input arm_isa_pkg::instr_word_t  in_instr,
  input logic                      out_valid,
  input arm_isa_pkg::instr_class_t out_class
);

  int fail_count = 0;

  // Output quiet through reset and the cycle after it
  assert property (@(posedge clk) (reset || $past(reset)) |=> !out_valid)
    else begin
      $error("out_valid high during reset or in the cycle after it");
      fail_count++;
    end

  // Fixed pipeline depth of three registers
  assert property (@(posedge clk) disable iff (reset)
                   !$past(reset, 3) |-> (out_valid == $past(in_valid, 3)))
    else begin
      $error("out_valid does not follow in_valid by 3 cycles");
      fail_count++;
    end

  // Bits 27:26 clear always land in a defined class
  assert property (@(posedge clk) disable iff (reset)
                   (out_valid && $past(in_valid, 3) && ($past(in_instr[27:26], 3) == 2'b00))
                   |-> (out_class != arm_isa_pkg::UNDEFINED))
    else begin
      $error("data processing space decoded as UNDEFINED");
      fail_count++;
    end

endmodule

bind decode_unit_top decode_unit_chk decode_unit_chk_i (
  .clk      (clk),
  .reset    (reset),
  .in_valid (in_valid),
  .in_instr (in_instr),
  .out_valid(out_valid),
  .out_class(out_class)
);

// File: dv/decode_unit_monitor.sv
`timescale 1ns/100ps

module decode_unit_monitor (
  input logic                      clk,
  input logic                      reset,
  input logic                      out_valid,
  input arm_isa_pkg::instr_class_t out_class,
  input logic                      out_cond_pass,
  input arm_isa_pkg::reg_index_t   out_rn,
  input arm_isa_pkg::reg_index_t   out_rd,
  input arm_isa_pkg::reg_index_t   out_rs,
  input arm_isa_pkg::reg_index_t   out_rm,
  input arm_isa_pkg::dp_opcode_t   out_opcode,
  input logic                      out_set_flags,
  input decode_pkg::imm8_t         out_imm8,
  input decode_pkg::rotate_t       out_rotate,
  input decode_pkg::shift_amount_t out_shift_amount,
  input arm_isa_pkg::shift_type_t  out_shift_type
);

  // Outstanding instructions, oldest first
  arm_isa_pkg::instr_word_t  exp_word  [$];
  arm_isa_pkg::instr_class_t exp_class [$];
  logic                      exp_pass  [$];

  int error_count = 0;

  task automatic push_expected(input arm_isa_pkg::instr_word_t word,
                               input arm_isa_pkg::instr_class_t cls,
                               input logic cond_ok);
    exp_word.push_back(word);
    exp_class.push_back(cls);
    exp_pass.push_back(cond_ok);
  endtask

  function automatic int pending_count();
    return exp_word.size();
  endfunction

  task automatic compare_field(input string name, input logic [7:0] got,
                               input logic [7:0] want);
    if (got !== want) begin
      $display("** Error at %0t ns: %s is 0x%0h, expected 0x%0h", $time, name, got, want);
      error_count++;
    end
  endtask

  // Sample on the falling edge, away from the register updates
  always @(negedge clk) begin
    arm_isa_pkg::instr_word_t  w;
    arm_isa_pkg::instr_class_t cls;
    logic                      cond_ok;
    logic                      is_dp;
    logic                      is_imm;
    logic                      is_shift;
    if (!reset && out_valid) begin
      if (exp_word.size() == 0) begin
        $display("Output at %0t ns arrived with no instruction outstanding", $time);
        error_count++;
      end else begin
        w        = exp_word.pop_front();
        cls      = exp_class.pop_front();
        cond_ok  = exp_pass.pop_front();
        is_imm   = (cls == arm_isa_pkg::DATAPROC_IMM);
        is_shift = (cls == arm_isa_pkg::DATAPROC_REG_IMM) ||
                   (cls == arm_isa_pkg::DATAPROC_REG_REG);
        is_dp    = is_imm || is_shift;
        compare_field("class", 8'(out_class), 8'(cls));
        compare_field("cond_pass", 8'(out_cond_pass), 8'(cond_ok));
        // Register indices come from fixed positions in every class
        compare_field("rn", 8'(out_rn), 8'(w[19:16]));
        compare_field("rd", 8'(out_rd), 8'(w[15:12]));
        compare_field("rs", 8'(out_rs), 8'(w[11:8]));
        compare_field("rm", 8'(out_rm), 8'(w[3:0]));
        compare_field("opcode", 8'(out_opcode), is_dp ? 8'(w[24:21]) : 8'h00);
        compare_field("set_flags", 8'(out_set_flags), 8'(is_dp && w[20]));
        compare_field("imm8", 8'(out_imm8), is_imm ? 8'(w[7:0]) : 8'h00);
        compare_field("rotate", 8'(out_rotate), is_imm ? 8'(w[11:8]) : 8'h00);
        compare_field("shift_amount", 8'(out_shift_amount),
                      (cls == arm_isa_pkg::DATAPROC_REG_IMM) ? 8'(w[11:7]) : 8'h00);
        compare_field("shift_type", 8'(out_shift_type), is_shift ? 8'(w[6:5]) : 8'h00);
      end
    end
  end

endmodule

// File: dv/decode_unit_tb.sv
`timescale 1ns/100ps

module decode_unit_tb;

  localparam int LANES = 4;

  logic                      clk;
  logic                      reset;
  logic                      in_valid;
  arm_isa_pkg::instr_word_t  in_instr;
  decode_pkg::flags_t        in_flags;
  logic                      out_valid;
  arm_isa_pkg::instr_class_t out_class;
  logic                      out_cond_pass;
  arm_isa_pkg::reg_index_t   out_rn;
  arm_isa_pkg::reg_index_t   out_rd;
  arm_isa_pkg::reg_index_t   out_rs;
  arm_isa_pkg::reg_index_t   out_rm;
  arm_isa_pkg::dp_opcode_t   out_opcode;
  logic                      out_set_flags;
  decode_pkg::imm8_t         out_imm8;
  decode_pkg::rotate_t       out_rotate;
  decode_pkg::shift_amount_t out_shift_amount;
  arm_isa_pkg::shift_type_t  out_shift_type;

  // Stimulus table: word, NZCV flags, expected class, expected condition pass
  arm_isa_pkg::instr_word_t  tbl_word  [$];
  decode_pkg::flags_t        tbl_flags [$];
  arm_isa_pkg::instr_class_t tbl_class [$];
  logic                      tbl_pass  [$];

  always #4 clk = ~clk;

  decode_unit_top #(
    .LANES(LANES)
  ) decode_unit_top_i (
    .clk(clk), .reset(reset), .in_valid(in_valid), .in_instr(in_instr),
    .in_flags(in_flags), .out_valid(out_valid), .out_class(out_class),
    .out_cond_pass(out_cond_pass), .out_rn(out_rn), .out_rd(out_rd),
    .out_rs(out_rs), .out_rm(out_rm), .out_opcode(out_opcode),
    .out_set_flags(out_set_flags), .out_imm8(out_imm8), .out_rotate(out_rotate),
    .out_shift_amount(out_shift_amount), .out_shift_type(out_shift_type)
  );

  decode_unit_monitor monitor_i (
    .clk(clk), .reset(reset), .out_valid(out_valid), .out_class(out_class),
    .out_cond_pass(out_cond_pass), .out_rn(out_rn), .out_rd(out_rd),
    .out_rs(out_rs), .out_rm(out_rm), .out_opcode(out_opcode),
    .out_set_flags(out_set_flags), .out_imm8(out_imm8), .out_rotate(out_rotate),
    .out_shift_amount(out_shift_amount), .out_shift_type(out_shift_type)
  );

  task automatic add_entry(input arm_isa_pkg::instr_word_t word,
                           input decode_pkg::flags_t flags,
                           input arm_isa_pkg::instr_class_t cls,
                           input logic cond_ok);
    tbl_word.push_back(word);
    tbl_flags.push_back(flags);
    tbl_class.push_back(cls);
    tbl_pass.push_back(cond_ok);
  endtask

  // Each condition code appears once passing and once failing
  task automatic fill_table();
    add_entry(32'h012F_FF13, 4'b0100, arm_isa_pkg::BX, 1'b1);
    add_entry(32'h18BD_00F0, 4'b0100, arm_isa_pkg::BLOCK_XFER, 1'b0);
    add_entry(32'h38BD_8000, 4'b0000, arm_isa_pkg::BLOCK_XFER, 1'b1);
    add_entry(32'h2A00_0010, 4'b0010, arm_isa_pkg::BRANCH, 1'b1);
    add_entry(32'h0A00_0004, 4'b0000, arm_isa_pkg::BRANCH, 1'b0);
    add_entry(32'h9A00_0000, 4'b0010, arm_isa_pkg::BRANCH, 1'b0);
    add_entry(32'h3B00_1234, 4'b0010, arm_isa_pkg::BRANCH_LINK, 1'b0);
    add_entry(32'h1B00_0008, 4'b0000, arm_isa_pkg::BRANCH_LINK, 1'b1);
    add_entry(32'h4F00_00AB, 4'b1000, arm_isa_pkg::SWI, 1'b1);
    add_entry(32'h2F00_0001, 4'b1101, arm_isa_pkg::SWI, 1'b0);
    add_entry(32'h5591_2004, 4'b1000, arm_isa_pkg::SINGLE_XFER, 1'b0);
    add_entry(32'h4591_0000, 4'b0111, arm_isa_pkg::SINGLE_XFER, 1'b0);
    add_entry(32'h6791_2103, 4'b0001, arm_isa_pkg::SINGLE_XFER, 1'b1);
    // Swap shares the 1001 marker with multiply
    add_entry(32'h7102_1093, 4'b0001, arm_isa_pkg::SWAP, 1'b0);
    add_entry(32'h5142_1093, 4'b0110, arm_isa_pkg::SWAP, 1'b1);
    add_entry(32'h8003_0291, 4'b0010, arm_isa_pkg::MUL, 1'b1);
    add_entry(32'h8031_4392, 4'b0110, arm_isa_pkg::MUL, 1'b0);
    add_entry(32'h6003_0291, 4'b1110, arm_isa_pkg::MUL, 1'b0);
    add_entry(32'h9081_2394, 4'b0110, arm_isa_pkg::MUL_LONG, 1'b1);
    add_entry(32'h7081_2394, 4'b0000, arm_isa_pkg::MUL_LONG, 1'b1);
    add_entry(32'hA191_20B3, 4'b1001, arm_isa_pkg::HALF_XFER_REG, 1'b1);
    add_entry(32'hB1D1_20F4, 4'b1001, arm_isa_pkg::HALF_XFER_IMM, 1'b0);
    // PSR transfers sit inside the data processing space
    add_entry(32'hC129_F003, 4'b0000, arm_isa_pkg::MSR, 1'b1);
    add_entry(32'hC328_F0FF, 4'b0100, arm_isa_pkg::MSR, 1'b0);
    add_entry(32'hD10F_0000, 4'b0100, arm_isa_pkg::MRS, 1'b1);
    add_entry(32'hD14F_1000, 4'b0000, arm_isa_pkg::MRS, 1'b0);
    add_entry(32'hE3A0_1CFF, 4'b0000, arm_isa_pkg::DATAPROC_IMM, 1'b1);
    add_entry(32'hE291_2E0A, 4'b1111, arm_isa_pkg::DATAPROC_IMM, 1'b1);
    add_entry(32'hA3A0_10FF, 4'b1000, arm_isa_pkg::DATAPROC_IMM, 1'b0);
    add_entry(32'hE1B0_3F45, 4'b0000, arm_isa_pkg::DATAPROC_REG_IMM, 1'b1);
    add_entry(32'hF081_2183, 4'b1111, arm_isa_pkg::DATAPROC_REG_IMM, 1'b0);
    add_entry(32'hE001_2356, 4'b0000, arm_isa_pkg::DATAPROC_REG_REG, 1'b1);
    add_entry(32'hB001_2356, 4'b0001, arm_isa_pkg::DATAPROC_REG_REG, 1'b1);
    add_entry(32'hE600_0010, 4'b0000, arm_isa_pkg::UNDEFINED, 1'b1);
    add_entry(32'hEC00_0000, 4'b1010, arm_isa_pkg::UNDEFINED, 1'b1);
    add_entry(32'hF600_0010, 4'b0000, arm_isa_pkg::UNDEFINED, 1'b0);
  endtask

  initial begin
    int gap;
    int waited;
    int missing;
    int assert_fails;
    void'($urandom(32'h5a0f_af34));
    clk      = 1'b0;
    reset    = 1'b1;
    in_valid = 1'b0;
    in_instr = '0;
    in_flags = '0;
    fill_table();
    repeat (16) @(posedge clk);
    reset <= 1'b0;
    // Idle stretch, nothing may come out before the first strobe
    repeat (6) @(posedge clk);

    // First round with random gaps, second round back to back
    for (int round = 0; round < 2; round++) begin
      for (int i = 0; i < tbl_word.size(); i++) begin
        @(posedge clk);
        in_valid <= 1'b1;
        in_instr <= tbl_word[i];
        in_flags <= tbl_flags[i];
        monitor_i.push_expected(tbl_word[i], tbl_class[i], tbl_pass[i]);
        gap = (round == 0) ? int'($urandom % 4) : 0;
        repeat (gap) begin
          @(posedge clk);
          in_valid <= 1'b0;
        end
      end
    end
    @(posedge clk);
    in_valid <= 1'b0;

    waited = 0;
    while (monitor_i.pending_count() != 0 && waited < 50) begin
      @(posedge clk);
      waited++;
    end
    missing = monitor_i.pending_count();
    if (missing != 0) begin
      $display("Timed out after 50 cycles with %0d results never produced", missing);
    end
    assert_fails = decode_unit_top_i.decode_unit_chk_i.fail_count;
    $display("Errors: %0d wrong values, %0d missing results, %0d assertion failures",
             monitor_i.error_count, missing, assert_fails);
    if (monitor_i.error_count == 0 && missing == 0 && assert_fails == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

// File: source/arm_isa_pkg.sv
package arm_isa_pkg;

  // Raw instruction word as fetched
  typedef logic [31:0] instr_word_t;

  // Register number, r0 to r15
  typedef logic [3:0] reg_index_t;

  // Data processing opcode field, bits 24:21
  typedef logic [3:0] dp_opcode_t;

  // Condition field, bits 31:28
  typedef enum logic [3:0] {
    EQ = 4'h0,
    NE = 4'h1,
    CS = 4'h2,
    CC = 4'h3,
    MI = 4'h4,
    PL = 4'h5,
    VS = 4'h6,
    VC = 4'h7,
    HI = 4'h8,
    LS = 4'h9,
    GE = 4'ha,
    LT = 4'hb,
    GT = 4'hc,
    LE = 4'hd,
    AL = 4'he,
    NV = 4'hf
  } condition_t;

  // Barrel shifter operation, bits 6:5
  typedef enum logic [1:0] {
    LSL = 2'b00,
    LSR = 2'b01,
    ASR = 2'b10,
    ROR = 2'b11
  } shift_type_t;

  // Instruction class, listed in match priority order
  typedef enum logic [4:0] {
    BX,
    BLOCK_XFER,
    BRANCH,
    BRANCH_LINK,
    SWI,
    SINGLE_XFER,
    SWAP,
    MUL,
    MUL_LONG,
    HALF_XFER_REG,
    HALF_XFER_IMM,
    MSR,
    MRS,
    DATAPROC_IMM,
    DATAPROC_REG_IMM,
    DATAPROC_REG_REG,
    UNDEFINED
  } instr_class_t;

endpackage

// File: source/decode_collect.sv
`timescale 1ns/100ps

module decode_collect #(
  parameter int LANES = 4
) (
  input  logic                      clk,
  input  logic                      reset,
  input  logic [LANES-1:0]          dec_valid,
  input  arm_isa_pkg::instr_class_t dec_class        [LANES],
  input  arm_isa_pkg::condition_t   dec_cond         [LANES],
  input  decode_pkg::flags_t        dec_flags        [LANES],
  input  arm_isa_pkg::reg_index_t   dec_rn           [LANES],
  input  arm_isa_pkg::reg_index_t   dec_rd           [LANES],
  input  arm_isa_pkg::reg_index_t   dec_rs           [LANES],
  input  arm_isa_pkg::reg_index_t   dec_rm           [LANES],
  input  arm_isa_pkg::dp_opcode_t   dec_opcode       [LANES],
  input  logic                      dec_set_flags    [LANES],
  input  decode_pkg::imm8_t         dec_imm8         [LANES],
  input  decode_pkg::rotate_t       dec_rotate       [LANES],
  input  decode_pkg::shift_amount_t dec_shift_amount [LANES],
  input  arm_isa_pkg::shift_type_t  dec_shift_type   [LANES],
  output logic                      out_valid,
  output arm_isa_pkg::instr_class_t out_class,
  output logic                      out_cond_pass,
  output arm_isa_pkg::reg_index_t   out_rn,
  output arm_isa_pkg::reg_index_t   out_rd,
  output arm_isa_pkg::reg_index_t   out_rs,
  output arm_isa_pkg::reg_index_t   out_rm,
  output arm_isa_pkg::dp_opcode_t   out_opcode,
  output logic                      out_set_flags,
  output decode_pkg::imm8_t         out_imm8,
  output decode_pkg::rotate_t       out_rotate,
  output decode_pkg::shift_amount_t out_shift_amount,
  output arm_isa_pkg::shift_type_t  out_shift_type
);

  // ARM condition rule against NZCV
  function automatic logic cond_pass(input arm_isa_pkg::condition_t cond,
                                     input decode_pkg::flags_t flags);
    logic n;
    logic z;
    logic c;
    logic v;
    n = flags[decode_pkg::FLAG_N];
    z = flags[decode_pkg::FLAG_Z];
    c = flags[decode_pkg::FLAG_C];
    v = flags[decode_pkg::FLAG_V];
    case (cond)
      arm_isa_pkg::EQ: cond_pass = z;
      arm_isa_pkg::NE: cond_pass = !z;
      arm_isa_pkg::CS: cond_pass = c;
      arm_isa_pkg::CC: cond_pass = !c;
      arm_isa_pkg::MI: cond_pass = n;
      arm_isa_pkg::PL: cond_pass = !n;
      arm_isa_pkg::VS: cond_pass = v;
      arm_isa_pkg::VC: cond_pass = !v;
      arm_isa_pkg::HI: cond_pass = c && !z;
      arm_isa_pkg::LS: cond_pass = !c || z;
      arm_isa_pkg::GE: cond_pass = (n == v);
      arm_isa_pkg::LT: cond_pass = (n != v);
      arm_isa_pkg::GT: cond_pass = !z && (n == v);
      arm_isa_pkg::LE: cond_pass = z || (n != v);
      arm_isa_pkg::AL: cond_pass = 1'b1;
      arm_isa_pkg::NV: cond_pass = 1'b0;
    endcase
    return cond_pass;
  endfunction

  arm_isa_pkg::condition_t sel_cond;
  decode_pkg::flags_t      sel_flags;
  logic                    any_valid;
  int unsigned             sel_lane;

  // dec_valid is one-hot, so the last match is the only one
  always_comb begin
    sel_lane = 0;
    for (int i = 0; i < LANES; i++) begin
      if (dec_valid[i]) begin
        sel_lane = i;
      end
    end
  end

  assign any_valid = |dec_valid;
  assign sel_cond  = dec_cond[sel_lane];
  assign sel_flags = dec_flags[sel_lane];

  always_ff @(posedge clk) begin
    if (reset) begin
      out_valid <= 1'b0;
    end else begin
      out_valid <= any_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (any_valid) begin
      out_class        <= dec_class[sel_lane];
      out_cond_pass    <= cond_pass(sel_cond, sel_flags);
      out_rn           <= dec_rn[sel_lane];
      out_rd           <= dec_rd[sel_lane];
      out_rs           <= dec_rs[sel_lane];
      out_rm           <= dec_rm[sel_lane];
      out_opcode       <= dec_opcode[sel_lane];
      out_set_flags    <= dec_set_flags[sel_lane];
      out_imm8         <= dec_imm8[sel_lane];
      out_rotate       <= dec_rotate[sel_lane];
      out_shift_amount <= dec_shift_amount[sel_lane];
      out_shift_type   <= dec_shift_type[sel_lane];
    end
  end

endmodule

// File: source/decode_pkg.sv
package decode_pkg;

  // Field widths of the decoded output
  localparam int FLAGS_W        = 4;
  localparam int IMM8_W         = 8;
  localparam int ROTATE_W       = 4;
  localparam int SHIFT_AMOUNT_W = 5;

  // Bit positions inside the flags vector, N on top
  localparam int FLAG_N = 3;
  localparam int FLAG_Z = 2;
  localparam int FLAG_C = 1;
  localparam int FLAG_V = 0;

  // NZCV condition flags that travel with each instruction
  typedef logic [FLAGS_W-1:0] flags_t;

  // Immediate operand of the data processing immediate form
  typedef logic [IMM8_W-1:0] imm8_t;

  // Rotate field, applied as twice this value
  typedef logic [ROTATE_W-1:0] rotate_t;

  // Shift amount of the register with immediate shift form
  typedef logic [SHIFT_AMOUNT_W-1:0] shift_amount_t;

endpackage

// File: source/decode_unit_top.sv
`timescale 1ns/100ps

module decode_unit_top #(
  parameter int LANES = 4
) (
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      in_valid,
  input  arm_isa_pkg::instr_word_t  in_instr,
  input  decode_pkg::flags_t        in_flags,
  output logic                      out_valid,
  output arm_isa_pkg::instr_class_t out_class,
  output logic                      out_cond_pass,
  output arm_isa_pkg::reg_index_t   out_rn,
  output arm_isa_pkg::reg_index_t   out_rd,
  output arm_isa_pkg::reg_index_t   out_rs,
  output arm_isa_pkg::reg_index_t   out_rm,
  output arm_isa_pkg::dp_opcode_t   out_opcode,
  output logic                      out_set_flags,
  output decode_pkg::imm8_t         out_imm8,
  output decode_pkg::rotate_t       out_rotate,
  output decode_pkg::shift_amount_t out_shift_amount,
  output arm_isa_pkg::shift_type_t  out_shift_type
);

  // Dispatcher to lanes
  logic [LANES-1:0]         lane_valid;
  arm_isa_pkg::instr_word_t lane_instr [LANES];
  decode_pkg::flags_t       lane_flags [LANES];

  // Lanes to collector
  logic [LANES-1:0]          dec_valid;
  arm_isa_pkg::instr_class_t dec_class        [LANES];
  arm_isa_pkg::condition_t   dec_cond         [LANES];
  decode_pkg::flags_t        dec_flags        [LANES];
  arm_isa_pkg::reg_index_t   dec_rn           [LANES];
  arm_isa_pkg::reg_index_t   dec_rd           [LANES];
  arm_isa_pkg::reg_index_t   dec_rs           [LANES];
  arm_isa_pkg::reg_index_t   dec_rm           [LANES];
  arm_isa_pkg::dp_opcode_t   dec_opcode       [LANES];
  logic                      dec_set_flags    [LANES];
  decode_pkg::imm8_t         dec_imm8         [LANES];
  decode_pkg::rotate_t       dec_rotate       [LANES];
  decode_pkg::shift_amount_t dec_shift_amount [LANES];
  arm_isa_pkg::shift_type_t  dec_shift_type   [LANES];

  instr_dispatch #(
    .LANES(LANES)
  ) instr_dispatch_i (
    .clk       (clk),
    .reset     (reset),
    .in_valid  (in_valid),
    .in_instr  (in_instr),
    .in_flags  (in_flags),
    .lane_valid(lane_valid),
    .lane_instr(lane_instr),
    .lane_flags(lane_flags)
  );

  for (genvar g = 0; g < LANES; g++) begin : g_lane
    instr_decode_lane instr_decode_lane_i (
      .clk             (clk),
      .reset           (reset),
      .in_valid        (lane_valid[g]),
      .in_instr        (lane_instr[g]),
      .in_flags        (lane_flags[g]),
      .dec_valid       (dec_valid[g]),
      .dec_class       (dec_class[g]),
      .dec_cond        (dec_cond[g]),
      .dec_flags       (dec_flags[g]),
      .dec_rn          (dec_rn[g]),
      .dec_rd          (dec_rd[g]),
      .dec_rs          (dec_rs[g]),
      .dec_rm          (dec_rm[g]),
      .dec_opcode      (dec_opcode[g]),
      .dec_set_flags   (dec_set_flags[g]),
      .dec_imm8        (dec_imm8[g]),
      .dec_rotate      (dec_rotate[g]),
      .dec_shift_amount(dec_shift_amount[g]),
      .dec_shift_type  (dec_shift_type[g])
    );
  end

  decode_collect #(
    .LANES(LANES)
  ) decode_collect_i (
    .clk             (clk),
    .reset           (reset),
    .dec_valid       (dec_valid),
    .dec_class       (dec_class),
    .dec_cond        (dec_cond),
    .dec_flags       (dec_flags),
    .dec_rn          (dec_rn),
    .dec_rd          (dec_rd),
    .dec_rs          (dec_rs),
    .dec_rm          (dec_rm),
    .dec_opcode      (dec_opcode),
    .dec_set_flags   (dec_set_flags),
    .dec_imm8        (dec_imm8),
    .dec_rotate      (dec_rotate),
    .dec_shift_amount(dec_shift_amount),
    .dec_shift_type  (dec_shift_type),
    .out_valid       (out_valid),
    .out_class       (out_class),
    .out_cond_pass   (out_cond_pass),
    .out_rn          (out_rn),
    .out_rd          (out_rd),
    .out_rs          (out_rs),
    .out_rm          (out_rm),
    .out_opcode      (out_opcode),
    .out_set_flags   (out_set_flags),
    .out_imm8        (out_imm8),
    .out_rotate      (out_rotate),
    .out_shift_amount(out_shift_amount),
    .out_shift_type  (out_shift_type)
  );

endmodule

// File: source/instr_decode_lane.sv
`timescale 1ns/100ps

module instr_decode_lane (
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      in_valid,
  input  arm_isa_pkg::instr_word_t  in_instr,
  input  decode_pkg::flags_t        in_flags,
  output logic                      dec_valid,
  output arm_isa_pkg::instr_class_t dec_class,
  output arm_isa_pkg::condition_t   dec_cond,
  output decode_pkg::flags_t        dec_flags,
  output arm_isa_pkg::reg_index_t   dec_rn,
  output arm_isa_pkg::reg_index_t   dec_rd,
  output arm_isa_pkg::reg_index_t   dec_rs,
  output arm_isa_pkg::reg_index_t   dec_rm,
  output arm_isa_pkg::dp_opcode_t   dec_opcode,
  output logic                      dec_set_flags,
  output decode_pkg::imm8_t         dec_imm8,
  output decode_pkg::rotate_t       dec_rotate,
  output decode_pkg::shift_amount_t dec_shift_amount,
  output arm_isa_pkg::shift_type_t  dec_shift_type
);

  arm_isa_pkg::instr_class_t nxt_class;
  arm_isa_pkg::dp_opcode_t   nxt_opcode;
  logic                      nxt_set_flags;
  decode_pkg::imm8_t         nxt_imm8;
  decode_pkg::rotate_t       nxt_rotate;
  decode_pkg::shift_amount_t nxt_shift_amount;
  arm_isa_pkg::shift_type_t  nxt_shift_type;

  // Class match, first pattern wins
  always_comb begin
    nxt_class        = arm_isa_pkg::UNDEFINED;
    nxt_opcode       = '0;
    nxt_set_flags    = 1'b0;
    nxt_imm8         = '0;
    nxt_rotate       = '0;
    nxt_shift_amount = '0;
    nxt_shift_type   = arm_isa_pkg::LSL;

    priority casez (in_instr)
      32'b????_0001_0010_1111_1111_1111_0001_????: nxt_class = arm_isa_pkg::BX;
      32'b????_100?_????_????_????_????_????_????: nxt_class = arm_isa_pkg::BLOCK_XFER;
      32'b????_1010_????_????_????_????_????_????: nxt_class = arm_isa_pkg::BRANCH;
      32'b????_1011_????_????_????_????_????_????: nxt_class = arm_isa_pkg::BRANCH_LINK;
      32'b????_1111_????_????_????_????_????_????: nxt_class = arm_isa_pkg::SWI;
      // Immediate offset, or register offset with bit 4 clear
      32'b????_010?_????_????_????_????_????_????: nxt_class = arm_isa_pkg::SINGLE_XFER;
      32'b????_011?_????_????_????_????_???0_????: nxt_class = arm_isa_pkg::SINGLE_XFER;
      32'b????_0001_0?00_????_????_0000_1001_????: nxt_class = arm_isa_pkg::SWAP;
      32'b????_0000_00??_????_????_????_1001_????: nxt_class = arm_isa_pkg::MUL;
      32'b????_0000_1???_????_????_????_1001_????: nxt_class = arm_isa_pkg::MUL_LONG;
      32'b????_000?_?0??_????_????_0000_1??1_????: nxt_class = arm_isa_pkg::HALF_XFER_REG;
      32'b????_000?_?1??_????_????_????_1??1_????: nxt_class = arm_isa_pkg::HALF_XFER_IMM;
      // Destination field is all ones for a PSR write
      32'b????_00?1_0?10_????_1111_????_????_????: nxt_class = arm_isa_pkg::MSR;
      32'b????_0001_0?00_1111_????_????_????_????: nxt_class = arm_isa_pkg::MRS;
      32'b????_00??_????_????_????_????_????_????: begin
        nxt_opcode    = in_instr[24:21];
        nxt_set_flags = in_instr[20];
        if (in_instr[25]) begin
          // Rotated 8-bit immediate
          nxt_class  = arm_isa_pkg::DATAPROC_IMM;
          nxt_imm8   = in_instr[7:0];
          nxt_rotate = in_instr[11:8];
        end else if (!in_instr[4]) begin
          // Register shifted by a constant
          nxt_class        = arm_isa_pkg::DATAPROC_REG_IMM;
          nxt_shift_amount = in_instr[11:7];
          nxt_shift_type   = arm_isa_pkg::shift_type_t'(in_instr[6:5]);
        end else begin
          // Shift amount comes from Rs
          nxt_class      = arm_isa_pkg::DATAPROC_REG_REG;
          nxt_shift_type = arm_isa_pkg::shift_type_t'(in_instr[6:5]);
        end
      end
      default: nxt_class = arm_isa_pkg::UNDEFINED;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      dec_valid <= 1'b0;
    end else begin
      dec_valid <= in_valid;
    end
  end

  // Register fields sit at fixed positions for every class
  always_ff @(posedge clk) begin
    if (in_valid) begin
      dec_class        <= nxt_class;
      dec_cond         <= arm_isa_pkg::condition_t'(in_instr[31:28]);
      dec_flags        <= in_flags;
      dec_rn           <= in_instr[19:16];
      dec_rd           <= in_instr[15:12];
      dec_rs           <= in_instr[11:8];
      dec_rm           <= in_instr[3:0];
      dec_opcode       <= nxt_opcode;
      dec_set_flags    <= nxt_set_flags;
      dec_imm8         <= nxt_imm8;
      dec_rotate       <= nxt_rotate;
      dec_shift_amount <= nxt_shift_amount;
      dec_shift_type   <= nxt_shift_type;
    end
  end

endmodule

// File: source/instr_dispatch.sv
`timescale 1ns/100ps

module instr_dispatch #(
  parameter int LANES = 4
) (
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     in_valid,
  input  arm_isa_pkg::instr_word_t in_instr,
  input  decode_pkg::flags_t       in_flags,
  output logic [LANES-1:0]         lane_valid,
  output arm_isa_pkg::instr_word_t lane_instr [LANES],
  output decode_pkg::flags_t       lane_flags [LANES]
);

  // Pointer needs at least one bit even with a single lane
  localparam int PTR_W = (LANES > 1) ? $clog2(LANES) : 1;

  logic [PTR_W-1:0] rr_ptr;

  // Round-robin pointer, one step per accepted instruction
  always_ff @(posedge clk) begin
    if (reset) begin
      rr_ptr <= '0;
    end else if (in_valid) begin
      if (rr_ptr == PTR_W'(LANES - 1)) begin
        rr_ptr <= '0;
      end else begin
        rr_ptr <= rr_ptr + 1'b1;
      end
    end
  end

  // One-hot strobe toward the selected lane
  always_ff @(posedge clk) begin
    if (reset) begin
      lane_valid <= '0;
    end else begin
      for (int i = 0; i < LANES; i++) begin
        lane_valid[i] <= in_valid && (rr_ptr == PTR_W'(i));
      end
    end
  end

  // Only the selected slot takes the new word and flags
  always_ff @(posedge clk) begin
    for (int i = 0; i < LANES; i++) begin
      if (in_valid && (rr_ptr == PTR_W'(i))) begin
        lane_instr[i] <= in_instr;
        lane_flags[i] <= in_flags;
      end
    end
  end

endmodule

// File: verilog.f
source/arm_isa_pkg.sv
source/decode_pkg.sv
source/instr_dispatch.sv
source/instr_decode_lane.sv
source/decode_collect.sv
source/decode_unit_top.sv
dv/decode_unit_chk.sv
dv/decode_unit_monitor.sv
dv/decode_unit_tb.sv
